/* memsys_defines.svh */
`ifndef MEMSYS_DEFINES_SVH
`define MEMSYS_DEFINES_SVH

// data ram geometry, word addressed
`define MEMSYS_RAM_WORDS 256
`define MEMSYS_ADDR_W $clog2(`MEMSYS_RAM_WORDS)

// machine word width
`define MEMSYS_DATA_W 32

// top three vaddr bits of the unmapped segments
`define MEMSYS_KSEG0 3'b100
`define MEMSYS_KSEG1 3'b101

`endif

/* memsysPkg.sv */
`include "memsys_defines.svh"

package memsysPkg;

    typedef logic [`MEMSYS_DATA_W-1:0] word_t;
    typedef logic [`MEMSYS_DATA_W/8-1:0] strobe_t;

    // access width of a load or store
    typedef enum logic [1:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4
    } msize_t;

    // cp0 event kind carried down the pipe
    typedef enum logic [1:0] {
        NONE,
        EXCEPTION,
        INTERRUPT,
        ERET
    } ctype_t;

    // address error flags, load and store side
    typedef struct packed {
        logic adelD;
        logic adesD;
    } etype_t;

    typedef struct packed {
        ctype_t ctype;
        etype_t etype;
        logic valid;
        word_t vaddr;
    } cp0Ctl_t;

    typedef struct packed {
        logic regwrite;
        logic memtoreg;
        logic memwrite;
        logic loadSigned;
        logic hiwrite;
        logic lowrite;
        logic cp0write;
        msize_t msize;
    } execCtl_t;

    // one lane as handed over by execute
    typedef struct packed {
        logic valid;
        word_t pc;
        logic [4:0] rdst;
        execCtl_t ctl;
        cp0Ctl_t cp0Ctl;
        word_t aluOut;
        word_t srca;
        word_t srcb;
    } execData_t;

    typedef struct packed {
        logic valid;
        word_t addr;
        msize_t size;
        strobe_t strobe;
        word_t data;
    } dbusReq_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        logic [4:0] rdst;
        logic regwrite;
        word_t result;
        cp0Ctl_t cp0Ctl;
    } memWb_t;

endpackage

/* addrTrans.sv */
`timescale 1ns/100ps
`include "memsys_defines.svh"

module addrTrans (
    input  memsysPkg::word_t vaddr,
    output memsysPkg::word_t paddr
);

    logic [2:0] segment;

    assign segment = vaddr[31:29];

    // kseg0 and kseg1 map onto the low 512MB, everything else untouched
    always_comb begin
        paddr = vaddr;
        if (segment == `MEMSYS_KSEG0 || segment == `MEMSYS_KSEG1) begin
            paddr[31:29] = 3'b000;
        end
    end

endmodule

/* storeAlign.sv */
`timescale 1ns/100ps

module storeAlign (
    input  logic [1:0] addrLow,
    input  memsysPkg::word_t srcb,
    input  memsysPkg::msize_t msize,
    output memsysPkg::word_t wd,
    output memsysPkg::strobe_t strobe,
    output logic storeMisalign
);

    always_comb begin
        wd = srcb;
        strobe = '0;
        storeMisalign = 1'b0;
        case (msize)
            memsysPkg::MSIZE1: begin
                // byte copied into every lane, strobe picks one
                wd = {4{srcb[7:0]}};
                strobe = 4'b0001 << addrLow;
            end
            memsysPkg::MSIZE2: begin
                wd = {2{srcb[15:0]}};
                if (addrLow[0]) begin
                    storeMisalign = 1'b1;
                end else begin
                    strobe = addrLow[1] ? 4'b1100 : 4'b0011;
                end
            end
            default: begin
                storeMisalign = (addrLow != 2'b00);
                if (!storeMisalign) begin
                    strobe = 4'b1111;
                end
            end
        endcase
    end

    // lowest enabled byte lane carries the low source byte
    always_comb begin
        assert (strobe == '0 || wd[8*addrLow +: 8] == srcb[7:0])
            else $error("storeAlign: low source byte not placed at offset %0d", addrLow);
    end

endmodule

/* memStage.sv */
`timescale 1ns/100ps

module memStage (
    input  memsysPkg::execData_t dataE [2],
    input  logic [1:0] reqFinish,
    output memsysPkg::execData_t dataE2 [2],
    output memsysPkg::dbusReq_t dreq [2],
    output logic excpM
);

    memsysPkg::word_t paddr [2];
    memsysPkg::word_t wd [2];
    memsysPkg::strobe_t strobe [2];
    logic [1:0] storeMisRaw;
    logic [1:0] storeMis;
    logic [1:0] loadMis;
    logic [1:0] misalign;
    logic [1:0] eventIn;
    logic [1:0] memOp;
    logic squashed;

    for (genvar i = 0; i < 2; i++) begin : gLane
        addrTrans uTrans (
            .vaddr(dataE[i].aluOut),
            .paddr(paddr[i])
        );

        storeAlign uAlign (
            .addrLow(dataE[i].aluOut[1:0]),
            .srcb(dataE[i].srcb),
            .msize(dataE[i].ctl.msize),
            .wd(wd[i]),
            .strobe(strobe[i]),
            .storeMisalign(storeMisRaw[i])
        );

        assign storeMis[i] = dataE[i].ctl.memwrite && storeMisRaw[i];
        assign loadMis[i] = dataE[i].ctl.memtoreg &&
            ((dataE[i].ctl.msize == memsysPkg::MSIZE2 && dataE[i].aluOut[0]) ||
             (dataE[i].ctl.msize == memsysPkg::MSIZE4 && dataE[i].aluOut[1:0] != 2'b00));
        assign misalign[i] = storeMis[i] || loadMis[i];
        assign eventIn[i] = (dataE[i].cp0Ctl.ctype == memsysPkg::EXCEPTION) ||
                            (dataE[i].cp0Ctl.ctype == memsysPkg::ERET);
        assign memOp[i] = dataE[i].ctl.memtoreg || dataE[i].ctl.memwrite;
    end

    // lane 1 is older, so only lane 0 can be killed
    assign squashed = eventIn[1] || misalign[1];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dreq[i] = '0;
            dreq[i].valid = memOp[i] && !eventIn[i] && !misalign[i] &&
                            !(i == 0 && squashed) && !reqFinish[i];
            dreq[i].addr = paddr[i];
            dreq[i].size = dataE[i].ctl.msize;
            dreq[i].strobe = dataE[i].ctl.memwrite ? strobe[i] : '0;
            dreq[i].data = wd[i];
        end
    end

    always_comb begin
        dataE2 = dataE;
        for (int i = 0; i < 2; i++) begin
            if (storeMis[i]) begin
                dataE2[i].cp0Ctl.ctype = memsysPkg::EXCEPTION;
                dataE2[i].cp0Ctl.etype.adesD = 1'b1;
                dataE2[i].cp0Ctl.valid = 1'b1;
                dataE2[i].cp0Ctl.vaddr = dataE[i].aluOut;
            end else if (loadMis[i]) begin
                dataE2[i].cp0Ctl.ctype = memsysPkg::EXCEPTION;
                dataE2[i].cp0Ctl.etype.adelD = 1'b1;
                dataE2[i].cp0Ctl.valid = 1'b1;
                dataE2[i].cp0Ctl.vaddr = dataE[i].aluOut;
            end
        end
        // younger lane keeps flowing but must not change any state
        if (squashed) begin
            dataE2[0].ctl.regwrite = 1'b0;
            dataE2[0].ctl.memtoreg = 1'b0;
            dataE2[0].ctl.memwrite = 1'b0;
            dataE2[0].ctl.hiwrite = 1'b0;
            dataE2[0].ctl.lowrite = 1'b0;
            dataE2[0].ctl.cp0write = 1'b0;
            dataE2[0].cp0Ctl.valid = 1'b0;
        end
    end

    // any cp0 event in either lane, including the ones raised here
    always_comb begin
        excpM = |misalign;
        for (int i = 0; i < 2; i++) begin
            if (dataE[i].cp0Ctl.ctype != memsysPkg::NONE) begin
                excpM = 1'b1;
            end
        end
    end

    // a store that reaches the bus always writes at least one byte
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            assert (!(dreq[i].valid && dataE[i].ctl.memwrite && dreq[i].strobe == '0))
                else $error("memStage: lane %0d store request enables no byte", i);
        end
    end

endmodule

/* dbusArbiter.sv */
`timescale 1ns/100ps
`include "memsys_defines.svh"

module dbusArbiter (
    input  logic clk,
    input  logic rst,
    input  memsysPkg::dbusReq_t dreq [2],
    input  logic advance,
    output logic [1:0] reqFinish,
    output memsysPkg::word_t rdata [2],
    output logic ramEn,
    output logic [`MEMSYS_ADDR_W-1:0] ramAddr,
    output memsysPkg::strobe_t ramStrobe,
    output memsysPkg::word_t ramWdata,
    input  memsysPkg::word_t ramRdata
);

    logic issueLane;
    logic respValid;
    logic respLane;
    memsysPkg::word_t rdataQ [2];

    // older lane first, lane 0 only once lane 1 is done
    assign issueLane = dreq[1].valid;
    assign ramEn = dreq[1].valid || dreq[0].valid;

    always_comb begin
        ramAddr = dreq[issueLane].addr[`MEMSYS_ADDR_W+1:2];
        ramStrobe = dreq[issueLane].strobe;
        ramWdata = dreq[issueLane].data;
    end

    // finish goes up with the ram edge, so the lane drops its request next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            reqFinish <= '0;
            respValid <= 1'b0;
            respLane <= 1'b0;
        end else begin
            respValid <= ramEn;
            respLane <= issueLane;
            if (advance) begin
                reqFinish <= '0;
            end else if (ramEn) begin
                reqFinish[issueLane] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respValid) begin
            rdataQ[respLane] <= ramRdata;
        end
    end

    // response cycle reads straight from the ram
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rdata[i] = rdataQ[i];
            if (respValid && respLane == i[0]) begin
                rdata[i] = ramRdata;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        respValid |-> !(ramEn && issueLane == respLane))
        else $error("dbusArbiter: lane %0d issued again while in flight", respLane);

endmodule

/* dataRam.sv */
`timescale 1ns/100ps
`include "memsys_defines.svh"

module dataRam (
    input  logic clk,
    input  logic en,
    input  logic [`MEMSYS_ADDR_W-1:0] addr,
    input  memsysPkg::strobe_t strobe,
    input  memsysPkg::word_t wdata,
    output memsysPkg::word_t rdata
);

    memsysPkg::word_t mem [`MEMSYS_RAM_WORDS];

    // read returns the word as it was before this cycle's write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < `MEMSYS_DATA_W / 8; b++) begin
                if (strobe[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

/* memResult.sv */
`timescale 1ns/100ps

module memResult (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  memsysPkg::execData_t dataE2 [2],
    input  memsysPkg::word_t rdata [2],
    output memsysPkg::memWb_t wb [2]
);

    logic [1:0] validQ;
    memsysPkg::memWb_t wbNext [2];
    memsysPkg::memWb_t wbQ [2];

    function automatic memsysPkg::word_t loadExtend(
        input memsysPkg::word_t rd,
        input logic [1:0] offset,
        input memsysPkg::msize_t size,
        input logic sext
    );
        memsysPkg::word_t shifted;
        memsysPkg::word_t value;
        // bring the addressed byte or half down to bit 0
        shifted = rd >> {offset, 3'b000};
        case (size)
            memsysPkg::MSIZE1: begin
                value = sext ? {{24{shifted[7]}}, shifted[7:0]} : {24'b0, shifted[7:0]};
            end
            memsysPkg::MSIZE2: begin
                value = sext ? {{16{shifted[15]}}, shifted[15:0]} : {16'b0, shifted[15:0]};
            end
            default: begin
                value = rd;
            end
        endcase
        return value;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wbNext[i].valid = dataE2[i].valid;
            wbNext[i].pc = dataE2[i].pc;
            wbNext[i].rdst = dataE2[i].rdst;
            wbNext[i].regwrite = dataE2[i].ctl.regwrite;
            wbNext[i].cp0Ctl = dataE2[i].cp0Ctl;
            if (dataE2[i].ctl.memtoreg) begin
                wbNext[i].result = loadExtend(rdata[i], dataE2[i].aluOut[1:0],
                                              dataE2[i].ctl.msize, dataE2[i].ctl.loadSigned);
            end else begin
                wbNext[i].result = dataE2[i].aluOut;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                validQ[i] <= advance && wbNext[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wbQ <= wbNext;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wb[i] = wbQ[i];
            wb[i].valid = validQ[i];
        end
    end

endmodule

/* memSubsystem.sv */
`timescale 1ns/100ps
`include "memsys_defines.svh"

module memSubsystem (
    input  logic clk,
    input  logic rst,
    input  memsysPkg::execData_t dataE [2],
    output logic stall,
    output logic excpM,
    output memsysPkg::memWb_t wb [2]
);

    memsysPkg::execData_t dataE2 [2];
    memsysPkg::dbusReq_t dreq [2];
    memsysPkg::word_t rdata [2];
    logic [1:0] reqFinish;
    logic advance;
    logic ramEn;
    logic [`MEMSYS_ADDR_W-1:0] ramAddr;
    memsysPkg::strobe_t ramStrobe;
    memsysPkg::word_t ramWdata;
    memsysPkg::word_t ramRdata;

    // hold execute until every lane's access is done
    assign stall = dreq[0].valid || dreq[1].valid;
    assign advance = !stall;

    memStage uStage (
        .dataE(dataE),
        .reqFinish(reqFinish),
        .dataE2(dataE2),
        .dreq(dreq),
        .excpM(excpM)
    );

    dbusArbiter uArb (
        .clk(clk),
        .rst(rst),
        .dreq(dreq),
        .advance(advance),
        .reqFinish(reqFinish),
        .rdata(rdata),
        .ramEn(ramEn),
        .ramAddr(ramAddr),
        .ramStrobe(ramStrobe),
        .ramWdata(ramWdata),
        .ramRdata(ramRdata)
    );

    dataRam uRam (
        .clk(clk),
        .en(ramEn),
        .addr(ramAddr),
        .strobe(ramStrobe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

    memResult uResult (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .dataE2(dataE2),
        .rdata(rdata),
        .wb(wb)
    );

endmodule

/* tbMemSubsystem.sv */
`timescale 1ns/100ps
`include "memsys_defines.svh"

module tbMemSubsystem;

    localparam int KALU = 0;
    localparam int KLOAD = 1;
    localparam int KSTORE = 2;
    localparam int KERET = 3;

    // what one wb lane should hold once its group advances
    typedef struct packed {
        logic chkRes;
        memsysPkg::word_t result;
        logic regwrite;
        memsysPkg::word_t pc;
        logic [4:0] rdst;
        memsysPkg::cp0Ctl_t cp0;
    } laneExp_t;

    logic clk;
    logic rst;
    memsysPkg::execData_t dataE [2];
    logic stall;
    logic excpM;
    memsysPkg::memWb_t wb [2];

    laneExp_t expLane [2];
    logic expExcp;
    int expCycles;
    logic grpActive;
    int cyc;
    string testName;
    logic [7:0] shadow [64];
    int seed;
    int errors;
    int timeouts;
    logic aborted;

    memSubsystem i_dut (
        .clk(clk),
        .rst(rst),
        .dataE(dataE),
        .stall(stall),
        .excpM(excpM),
        .wb(wb)
    );

    always #20 clk = ~clk;

    // cycles since the current group arrived, counting the arrival cycle
    always @(posedge clk) begin
        if (!grpActive) begin
            cyc <= 1;
        end else begin
            cyc <= cyc + 1;
        end
    end

    for (genvar i = 0; i < 2; i++) begin : gLaneCheck
        assert property (@(posedge clk) disable iff (rst)
            wb[i].valid && expLane[i].chkRes |-> wb[i].result == expLane[i].result)
            else begin
                errors++;
                $display("MISMATCH %s lane %0d result: expected %h, actual %h",
                         testName, i, expLane[i].result, $sampled(wb[i].result));
            end
        assert property (@(posedge clk) disable iff (rst)
            wb[i].valid |-> wb[i].regwrite == expLane[i].regwrite)
            else begin
                errors++;
                $display("MISMATCH %s lane %0d regwrite: expected %0b, actual %0b",
                         testName, i, expLane[i].regwrite, $sampled(wb[i].regwrite));
            end
        assert property (@(posedge clk) disable iff (rst)
            wb[i].valid |-> wb[i].pc == expLane[i].pc && wb[i].rdst == expLane[i].rdst)
            else begin
                errors++;
                $display("MISMATCH %s lane %0d pc/rdst: expected %h/%0d, actual %h/%0d",
                         testName, i, expLane[i].pc, expLane[i].rdst,
                         $sampled(wb[i].pc), $sampled(wb[i].rdst));
            end
        assert property (@(posedge clk) disable iff (rst)
            wb[i].valid |-> wb[i].cp0Ctl == expLane[i].cp0)
            else begin
                errors++;
                $display("MISMATCH %s lane %0d cp0Ctl: expected %h, actual %h",
                         testName, i, expLane[i].cp0, $sampled(wb[i].cp0Ctl));
            end
    end

    assert property (@(posedge clk) disable iff (rst) grpActive |-> excpM == expExcp)
        else begin
            errors++;
            $display("MISMATCH %s excpM: expected %0b, actual %0b",
                     testName, expExcp, $sampled(excpM));
        end

    assert property (@(posedge clk) disable iff (rst) grpActive && !stall |-> cyc == expCycles)
        else begin
            errors++;
            $display("MISMATCH %s cycles to advance: expected %0d, actual %0d",
                     testName, expCycles, $sampled(cyc));
        end

    assert property (@(posedge clk) disable iff (rst)
        grpActive && !stall |=> wb[0].valid && wb[1].valid)
        else begin
            errors++;
            $display("wb valid bits did not rise after the group advanced in %s", testName);
        end

    function automatic memsysPkg::word_t segAddr(input logic [2:0] seg, input int off);
        return {seg, 23'd0, off[5:0]};
    endfunction

    function automatic memsysPkg::word_t randAddr(input int off);
        logic [2:0] seg;
        seg = ($random(seed) & 1) ? `MEMSYS_KSEG1 : `MEMSYS_KSEG0;
        return segAddr(seg, off);
    endfunction

    function automatic memsysPkg::execData_t makeLane(input int kind, input memsysPkg::word_t addr,
            input memsysPkg::msize_t size, input logic sgn, input memsysPkg::word_t data);
        memsysPkg::execData_t l;
        memsysPkg::word_t rnd;
        l = '0;
        l.valid = 1'b1;
        rnd = $random(seed);
        l.pc = {rnd[31:2], 2'b00};
        rnd = $random(seed);
        l.rdst = rnd[4:0];
        l.aluOut = addr;
        l.srcb = data;
        l.ctl.msize = size;
        l.ctl.loadSigned = sgn;
        l.cp0Ctl.ctype = memsysPkg::NONE;
        case (kind)
            KLOAD: begin
                l.ctl.regwrite = 1'b1;
                l.ctl.memtoreg = 1'b1;
            end
            KSTORE: l.ctl.memwrite = 1'b1;
            KERET: begin
                l.cp0Ctl.ctype = memsysPkg::ERET;
                l.cp0Ctl.valid = 1'b1;
            end
            default: l.ctl.regwrite = 1'b1;
        endcase
        return l;
    endfunction

    function automatic int byteCount(input memsysPkg::msize_t size);
        case (size)
            memsysPkg::MSIZE1: return 1;
            memsysPkg::MSIZE2: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic misaligned(input memsysPkg::msize_t size, input logic [1:0] low);
        return (size == memsysPkg::MSIZE2 && low[0]) ||
               (size == memsysPkg::MSIZE4 && low != 2'b00);
    endfunction

    // little endian bytes, stored from the low bytes of srcb
    function automatic void shadowStore(input int off, input memsysPkg::msize_t size,
                                        input memsysPkg::word_t data);
        for (int b = 0; b < byteCount(size); b++) begin
            shadow[off + b] = data[8*b +: 8];
        end
    endfunction

    function automatic memsysPkg::word_t shadowLoad(input int off, input memsysPkg::msize_t size,
                                                    input logic sgn);
        memsysPkg::word_t v;
        int n;
        n = byteCount(size);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = shadow[off + b];
        end
        if (sgn && n < 4 && v[8*n-1]) begin
            for (int b = n; b < 4; b++) begin
                v[8*b +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic runGroup(input string name, input memsysPkg::execData_t l1,
                            input memsysPkg::execData_t l0);
        memsysPkg::execData_t lanes [2];
        laneExp_t e [2];
        memsysPkg::cp0Ctl_t cp;
        logic isLoad;
        logic isStore;
        logic mis;
        logic evt;
        logic squash;
        logic killYounger;
        logic excp;
        int accesses;
        int waited;
        logic dropped;
        if (aborted) begin
            return;
        end
        lanes[1] = l1;
        lanes[0] = l0;
        killYounger = 1'b0;
        excp = 1'b0;
        accesses = 0;
        // older lane first so its store is seen by a younger load
        for (int k = 1; k >= 0; k--) begin
            isLoad = lanes[k].ctl.memtoreg;
            isStore = lanes[k].ctl.memwrite;
            mis = (isLoad || isStore) && misaligned(lanes[k].ctl.msize, lanes[k].aluOut[1:0]);
            evt = lanes[k].cp0Ctl.ctype == memsysPkg::EXCEPTION ||
                  lanes[k].cp0Ctl.ctype == memsysPkg::ERET;
            squash = (k == 0) && killYounger;
            cp = lanes[k].cp0Ctl;
            if (mis) begin
                cp.ctype = memsysPkg::EXCEPTION;
                cp.valid = 1'b1;
                cp.vaddr = lanes[k].aluOut;
                cp.etype.adelD = isLoad;
                cp.etype.adesD = isStore;
            end
            if (squash) begin
                cp.valid = 1'b0;
            end
            e[k].cp0 = cp;
            e[k].regwrite = lanes[k].ctl.regwrite && !squash;
            e[k].pc = lanes[k].pc;
            e[k].rdst = lanes[k].rdst;
            e[k].chkRes = !mis && !squash;
            e[k].result = lanes[k].aluOut;
            if ((isLoad || isStore) && !mis && !squash && !evt) begin
                accesses++;
                if (isLoad) begin
                    e[k].result = shadowLoad(lanes[k].aluOut[5:0], lanes[k].ctl.msize,
                                             lanes[k].ctl.loadSigned);
                end else begin
                    shadowStore(lanes[k].aluOut[5:0], lanes[k].ctl.msize, lanes[k].srcb);
                end
            end
            if (mis || lanes[k].cp0Ctl.ctype != memsysPkg::NONE) begin
                excp = 1'b1;
            end
            if (k == 1) begin
                killYounger = mis || evt;
            end
        end
        @(posedge clk);
        dataE[1] <= l1;
        dataE[0] <= l0;
        expLane[1] <= e[1];
        expLane[0] <= e[0];
        expExcp <= excp;
        expCycles <= accesses + 1;
        grpActive <= 1'b1;
        testName = name;
        dropped = 1'b0;
        waited = 0;
        while (!dropped && waited < 10) begin
            @(negedge clk);
            if (!stall) begin
                dropped = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!dropped) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: stall stayed high for %0d cycles in %s", waited, name);
        end
        @(posedge clk);
        dataE[1] <= '0;
        dataE[0] <= '0;
        grpActive <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int base;
        memsysPkg::execData_t first;
        seed = 15554;
        errors = 0;
        timeouts = 0;
        aborted = 1'b0;
        clk = 1'b0;
        rst = 1'b1;
        dataE[0] = '0;
        dataE[1] = '0;
        expLane[0] = '0;
        expLane[1] = '0;
        expExcp = 1'b0;
        expCycles = 1;
        grpActive = 1'b0;
        cyc = 1;
        testName = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // fill the 16 words in use, two stores per group
        for (int w = 0; w < 8; w++) begin
            runGroup("preload",
                     makeLane(KSTORE, randAddr(8 * w), memsysPkg::MSIZE4, 1'b0, $random(seed)),
                     makeLane(KSTORE, randAddr(8 * w + 4), memsysPkg::MSIZE4, 1'b0, $random(seed)));
        end
        for (int n = 0; n < 4; n++) begin
            base = ($random(seed) & 15) * 4;
            runGroup("word store", makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KSTORE, randAddr(base), memsysPkg::MSIZE4, 1'b0, $random(seed)));
            runGroup("word load", makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
        end
        for (int n = 0; n < 6; n++) begin
            base = ($random(seed) & 15) * 4;
            runGroup("subword store",
                     makeLane(KSTORE, randAddr(base + n % 4), memsysPkg::MSIZE1, 1'b0,
                              $random(seed)),
                     makeLane(KSTORE, randAddr(base + 2 * (n % 2)), memsysPkg::MSIZE2, 1'b0,
                              $random(seed)));
            for (int o = 0; o < 4; o++) begin
                runGroup("byte load",
                         makeLane(KLOAD, randAddr(base + o), memsysPkg::MSIZE1, 1'b1, 0),
                         makeLane(KLOAD, randAddr(base + o), memsysPkg::MSIZE1, 1'b0, 0));
            end
            for (int o = 0; o < 4; o += 2) begin
                runGroup("half load",
                         makeLane(KLOAD, randAddr(base + o), memsysPkg::MSIZE2, 1'b1, 0),
                         makeLane(KLOAD, randAddr(base + o), memsysPkg::MSIZE2, 1'b0, 0));
            end
            runGroup("subword word load",
                     makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
        end
        for (int n = 0; n < 4; n++) begin
            base = ($random(seed) & 15) * 4;
            runGroup("misaligned store", makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KSTORE, randAddr(base + 1 + n % 3), memsysPkg::MSIZE4, 1'b0,
                              $random(seed)));
            runGroup("misaligned half store",
                     makeLane(KSTORE, randAddr(base + 1 + 2 * (n % 2)), memsysPkg::MSIZE2, 1'b0,
                              $random(seed)),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
            runGroup("misaligned load", makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KLOAD, randAddr(base + 1 + 2 * (n % 2)), memsysPkg::MSIZE2, 1'b1, 0));
            runGroup("memory unchanged", makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
        end
        for (int n = 0; n < 4; n++) begin
            base = ($random(seed) & 15) * 4;
            if (n % 2 == 1) begin
                first = makeLane(KERET, 0, memsysPkg::MSIZE4, 1'b0, 0);
            end else begin
                first = makeLane(KLOAD, randAddr(base + 2), memsysPkg::MSIZE4, 1'b0, 0);
            end
            runGroup("squash store", first,
                     makeLane(KSTORE, randAddr(base), memsysPkg::MSIZE4, 1'b0, $random(seed)));
            runGroup("squash load", first,
                     makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b1, 0));
            // younger event must lose its cp0 valid bit
            runGroup("squash eret", first, makeLane(KERET, 0, memsysPkg::MSIZE4, 1'b0, 0));
            runGroup("squash check", makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
        end
        for (int n = 0; n < 4; n++) begin
            base = ($random(seed) & 15) * 4;
            runGroup("lane order",
                     makeLane(KSTORE, randAddr(base), memsysPkg::MSIZE4, 1'b0, $random(seed)),
                     makeLane(KLOAD, randAddr(base), memsysPkg::MSIZE4, 1'b0, 0));
        end
        // same offset, segment code differs only
        for (int n = 0; n < 4; n++) begin
            base = ($random(seed) & 15) * 4;
            runGroup("kseg alias store",
                     makeLane(KSTORE, segAddr(n % 2 ? `MEMSYS_KSEG1 : `MEMSYS_KSEG0, base),
                              memsysPkg::MSIZE4, 1'b0, $random(seed)),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
            runGroup("kseg alias load",
                     makeLane(KLOAD, segAddr(n % 2 ? `MEMSYS_KSEG0 : `MEMSYS_KSEG1, base),
                              memsysPkg::MSIZE4, 1'b0, 0),
                     makeLane(KALU, $random(seed), memsysPkg::MSIZE4, 1'b0, 0));
        end

        @(posedge clk);
        $display("%0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* memSubsystem.f */
+incdir+.
memsysPkg.sv
addrTrans.sv
storeAlign.sv
memStage.sv
dbusArbiter.sv
dataRam.sv
memResult.sv
memSubsystem.sv
tbMemSubsystem.sv

/* run.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
{ verilator --binary --timing --assert -Wno-fatal --top-module tbMemSubsystem \
    -f memSubsystem.f -Mdir obj_dir > build.log 2>&1 &&
  ./obj_dir/VtbMemSubsystem > sim.log 2>&1; } ||
  echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } ||
  { echo "simulation passed"; exit 0; }
